// ==== commit/commit_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module commit_stage import commit_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    // executed pair, slot 1 older
    input  op_t   [1:0]          op,
    input  word_t [1:0]          result,
    input  word_t [1:0]          store_data,
    input  word_t [1:0]          srca,
    input  word_t [1:0]          pc,
    input  word_t [1:0]          pcbranch,
    input  word_t [1:0]          pcjump,
    input  logic  [1:0][4:0]     destreg,
    input  logic  [1:0]          regwrite,
    input  logic  [1:0]          overflow,
    input  logic  [1:0]          taken,
    input  logic  [1:0]          pred_taken,
    input  word_t [1:0]          epc,
    input  logic                 first_cycle,
    input  logic  [5:0]          ext_int,
    input  logic                 timer_interrupt,
    // data memory
    output logic                 dmem_en,
    output logic                 dmem_wt,
    output word_t                dmem_addr,
    output word_t                dmem_wd,
    output logic  [3:0]          dmem_be,
    input  word_t                dmem_rd,
    input  logic                 dmem_data_ok,
    // results
    output logic                 finish,
    output logic  [1:0]          wb_en,
    output logic  [1:0][4:0]     wb_reg,
    output word_t [1:0]          wb_data,
    output logic                 exception_valid,
    output exc_code_t            exception_code,
    output word_t                exception_pc,
    output logic                 redirect_valid,
    output word_t                redirect_pc
);

    logic      [1:0]      exc_valid;
    exc_code_t [1:0]      exc_code;
    word_t     [1:0]      exc_pc;
    word_t     [1:0]      slot_wd;
    logic      [1:0][3:0] slot_be;
    logic                 mask;
    logic                 sel_old;
    op_t                  mem_op;
    word_t                load_data;
    logic                 eret_old;
    logic                 eret_young;
    logic                 jr_old;
    logic                 branch_miss;
    logic                 jump_miss;

    exception_checker exception_checker_1 (
        .op(op[1]), .result(result[1]), .pc(pc[1]), .overflow(overflow[1]),
        .ext_int(ext_int), .timer_interrupt(timer_interrupt),
        .exc_valid(exc_valid[1]), .exc_code(exc_code[1]), .exc_pc(exc_pc[1])
    );

    exception_checker exception_checker_0 (
        .op(op[0]), .result(result[0]), .pc(pc[0]), .overflow(overflow[0]),
        .ext_int(ext_int), .timer_interrupt(timer_interrupt),
        .exc_valid(exc_valid[0]), .exc_code(exc_code[0]), .exc_pc(exc_pc[0])
    );

    // older slot faulting or returning kills the younger one
    assign mask = exc_valid[1] | (op[1] == OP_ERET);

    writedata_format writedata_format_1 (
        .op(op[1]), .addr_low(result[1][1:0]), .store_data(store_data[1]),
        .wd(slot_wd[1]), .be(slot_be[1])
    );

    writedata_format writedata_format_0 (
        .op(op[0]), .addr_low(result[0][1:0]), .store_data(store_data[0]),
        .wd(slot_wd[0]), .be(slot_be[0])
    );

    // single memory port, older slot wins
    assign sel_old   = is_mem(op[1]);
    assign mem_op    = sel_old ? op[1] : op[0];
    assign dmem_en   = sel_old ? ~exc_valid[1] : (is_mem(op[0]) & ~mask & ~exc_valid[0]);
    assign dmem_wt   = is_store(mem_op);
    assign dmem_addr = sel_old ? result[1] : result[0];
    assign dmem_wd   = sel_old ? slot_wd[1] : slot_wd[0];
    assign dmem_be   = sel_old ? slot_be[1] : slot_be[0];

    readdata_format readdata_format_i (
        .rd(dmem_rd), .addr_low(dmem_addr[1:0]), .op(mem_op), .load_data(load_data)
    );

    // a data_ok seen on the first cycle belongs to an earlier pair
    assign finish = first_cycle ? ~dmem_en : (~dmem_en | dmem_data_ok);

    assign wb_en[1]   = regwrite[1] & ~exc_valid[1];
    assign wb_en[0]   = regwrite[0] & ~exc_valid[0] & ~mask;
    assign wb_reg     = destreg;
    assign wb_data[1] = is_load(op[1]) ? load_data : result[1];
    assign wb_data[0] = (is_load(op[0]) && !sel_old) ? load_data : result[0];

    assign exception_valid = exc_valid[1] | (exc_valid[0] & ~mask);
    assign exception_code  = exc_valid[1] ? exc_code[1] : exc_code[0];
    assign exception_pc    = exc_valid[1] ? exc_pc[1] : exc_pc[0];

    // control flow resolved in the older slot only
    assign eret_old    = op[1] == OP_ERET;
    assign eret_young  = (op[0] == OP_ERET) & ~mask;
    assign jr_old      = op[1] == OP_JR;
    assign branch_miss = (op[1] == OP_BRANCH) & (taken[1] != pred_taken[1]);
    assign jump_miss   = (op[1] == OP_JUMP) & ~pred_taken[1];

    always_comb begin
        redirect_valid = 1'b1;
        redirect_pc    = EXC_VECTOR;
        if (exception_valid) begin
            redirect_pc = EXC_VECTOR;
        end else if (eret_old) begin
            redirect_pc = epc[1];
        end else if (eret_young) begin
            redirect_pc = epc[0];
        end else if (jr_old) begin
            redirect_pc = srca[1];
        end else if (branch_miss) begin
            // predicted taken but fell through, resume at the younger slot
            redirect_pc = taken[1] ? pcbranch[1] : pc[0];
        end else if (jump_miss) begin
            redirect_pc = pcjump[1];
        end else begin
            redirect_valid = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== commit/exception_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module exception_checker import commit_pkg::*; (
    input  op_t        op,
    input  word_t      result,
    input  word_t      pc,
    input  logic       overflow,
    input  logic [5:0] ext_int,
    input  logic       timer_interrupt,
    output logic       exc_valid,
    output exc_code_t  exc_code,
    output word_t      exc_pc
);

    logic interrupt;
    logic addr_err;

    assign interrupt = (|ext_int) | timer_interrupt;
    assign addr_err  = is_misaligned(op, result[1:0]);

    // interrupts first, then address errors, then instruction faults
    always_comb begin
        exc_valid = 1'b1;
        exc_code  = EXC_INT;
        if (interrupt) begin
            exc_code = EXC_INT;
        end else if (addr_err && is_load(op)) begin
            exc_code = EXC_ADEL;
        end else if (addr_err && is_store(op)) begin
            exc_code = EXC_ADES;
        end else if (op == OP_SYSCALL) begin
            exc_code = EXC_SYS;
        end else if (op == OP_BREAK) begin
            exc_code = EXC_BP;
        end else if (op == OP_RESERVED) begin
            exc_code = EXC_RI;
        end else if (op == OP_ALU && overflow) begin
            exc_code = EXC_OV;
        end else begin
            exc_valid = 1'b0;
        end
    end

    // EPC always points at the faulting instruction itself
    assign exc_pc = pc;

endmodule

`default_nettype wire

// ==== commit/readdata_format.sv ====
`timescale 1ns/10ps
`default_nettype none

module readdata_format import commit_pkg::*; (
    input  word_t      rd,
    input  logic [1:0] addr_low,
    input  op_t        op,
    output word_t      load_data
);

    load_word_u  word;
    logic [7:0]  lane_byte;
    logic [15:0] lane_half;

    assign word = rd;

    // lane select, memory is little endian
    assign lane_byte = word.bytes[addr_low];
    assign lane_half = word.halves[addr_low[1]];

    always_comb begin
        case (op)
            OP_LB: begin
                load_data = {{24{lane_byte[7]}}, lane_byte};
            end
            OP_LBU: begin
                load_data = {24'b0, lane_byte};
            end
            OP_LH: begin
                load_data = {{16{lane_half[15]}}, lane_half};
            end
            OP_LHU: begin
                load_data = {16'b0, lane_half};
            end
            default: begin
                // LW, whole word as returned
                load_data = rd;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== commit/writedata_format.sv ====
`timescale 1ns/10ps
`default_nettype none

module writedata_format import commit_pkg::*; (
    input  op_t        op,
    input  logic [1:0] addr_low,
    input  word_t      store_data,
    output word_t      wd,
    output logic [3:0] be
);

    always_comb begin
        wd = store_data;
        be = 4'b0000;
        case (op)
            OP_SB: begin
                // byte copied into every lane, enable picks one
                wd = {4{store_data[7:0]}};
                be = 4'b0001 << addr_low;
            end
            OP_SH: begin
                wd = {2{store_data[15:0]}};
                be = addr_low[1] ? 4'b1100 : 4'b0011;
            end
            OP_SW: begin
                be = 4'b1111;
            end
            default: begin
                // loads and non-memory ops write nothing
                be = 4'b0000;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== common/commit_pkg.sv ====
`default_nettype none

package commit_pkg;

    typedef logic [31:0] word_t;

    // decoded operation class of an executed instruction
    typedef enum logic [3:0] {
        OP_ALU,
        OP_LB,
        OP_LBU,
        OP_LH,
        OP_LHU,
        OP_LW,
        OP_SB,
        OP_SH,
        OP_SW,
        OP_BRANCH,
        OP_JUMP,
        OP_JR,
        OP_ERET,
        OP_SYSCALL,
        OP_BREAK,
        OP_RESERVED
    } op_t;

    // cause register exception codes
    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_SYS  = 5'd8,
        EXC_BP   = 5'd9,
        EXC_RI   = 5'd10,
        EXC_OV   = 5'd12
    } exc_code_t;

    // general exception entry, BEV=1
    localparam word_t EXC_VECTOR = 32'hbfc00380;

    // a loaded word, seen by byte lane or by halfword lane
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } load_word_u;

    function automatic logic is_load(op_t op);
        return (op == OP_LB) || (op == OP_LBU) || (op == OP_LH) ||
               (op == OP_LHU) || (op == OP_LW);
    endfunction

    function automatic logic is_store(op_t op);
        return (op == OP_SB) || (op == OP_SH) || (op == OP_SW);
    endfunction

    function automatic logic is_mem(op_t op);
        return is_load(op) || is_store(op);
    endfunction

    // true when the access size needs alignment the address lacks
    function automatic logic is_misaligned(op_t op, logic [1:0] addr_low);
        case (op)
            OP_LH, OP_LHU, OP_SH: return addr_low[0];
            OP_LW, OP_SW:         return addr_low != 2'b00;
            default:              return 1'b0;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== dv/commit_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module commit_tb import commit_pkg::*; ;

    localparam int MEM_WORDS    = 256;
    localparam int READ_LATENCY = 2;
    localparam int RESET_CYCLES = 10;
    localparam int CYCLE_LIMIT  = 400 * (READ_LATENCY + 3) + RESET_CYCLES;
    localparam word_t BASE      = 32'h1000_0000;

    logic clk, rst_n, first_cycle, timer_interrupt;
    op_t   [1:0] op;
    word_t [1:0] result, store_data, srca, pc, pcbranch, pcjump, epc, wb_data;
    logic  [1:0][4:0] destreg, wb_reg;
    logic  [1:0] regwrite, overflow, taken, pred_taken, wb_en;
    logic  [5:0] ext_int;
    logic finish, exception_valid, redirect_valid;
    exc_code_t exception_code;
    word_t exception_pc, redirect_pc;

    integer seed = 32'h57f96e5b;
    int errors = 0;
    int checks = 0;
    int cycle_count = 0;
    logic [31:0] shadow [MEM_WORDS];

    commit_top #(.MEM_WORDS(MEM_WORDS), .READ_LATENCY(READ_LATENCY)) commit_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout, a pair never finished within the cycle limit");
            $display("Regression failed");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic logic mem_load(op_t o);
        return o inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
    endfunction

    function automatic logic mem_store(op_t o);
        return o inside {OP_SB, OP_SH, OP_SW};
    endfunction

    // expected cause for one slot, valid flag in bit 5
    function automatic logic [5:0] slot_cause(op_t o, word_t a, logic ovf);
        logic bad;
        bad = ((o inside {OP_LH, OP_LHU, OP_SH}) && a[0]) ||
              ((o inside {OP_LW, OP_SW}) && (a[1:0] != 2'b00));
        if ((|ext_int) || timer_interrupt) return {1'b1, 5'd0};
        if (bad && mem_load(o)) return {1'b1, 5'd4};
        if (bad && mem_store(o)) return {1'b1, 5'd5};
        if (o == OP_SYSCALL) return {1'b1, 5'd8};
        if (o == OP_BREAK) return {1'b1, 5'd9};
        if (o == OP_RESERVED) return {1'b1, 5'd10};
        if (o == OP_ALU && ovf) return {1'b1, 5'd12};
        return 6'd0;
    endfunction

    function automatic word_t extract(op_t o, word_t w, logic [1:0] a);
        logic [7:0] b;
        logic [15:0] h;
        b = w[8*a +: 8];
        h = a[1] ? w[31:16] : w[15:0];
        case (o)
            OP_LB:   return {{24{b[7]}}, b};
            OP_LBU:  return {24'h0, b};
            OP_LH:   return {{16{h[15]}}, h};
            OP_LHU:  return {16'h0, h};
            default: return w;
        endcase
    endfunction

    // quiet pair, targets differ per slot
    task automatic set_defaults();
        for (int s = 0; s < 2; s++) begin
            op[s] = OP_ALU;
            result[s] = 32'h0;
            store_data[s] = 32'h0;
            srca[s] = 32'h0;
            pc[s] = 32'h0040_0104 - 4 * s;
            pcbranch[s] = 32'h0040_0200 + 32'h10 * s;
            pcjump[s] = 32'h0040_0300 + 32'h10 * s;
            epc[s] = 32'h0040_0400 + 32'h10 * s;
            destreg[s] = 5'(s + 2);
            regwrite[s] = 1'b0;
            overflow[s] = 1'b0;
            taken[s] = 1'b0;
            pred_taken[s] = 1'b0;
        end
        ext_int = 6'h0;
        timer_interrupt = 1'b0;
    endtask

    task automatic begin_pair();
        @(negedge clk);
        set_defaults();
    endtask

    task automatic run_pair();
        logic [5:0] c1, c0;
        logic mask, exc_v, acc, rv;
        logic [1:0] en_exp;
        int ms, cyc, idx;
        word_t rpc, w;
        first_cycle = 1'b1;
        #1;
        c1 = slot_cause(op[1], result[1], overflow[1]);
        c0 = slot_cause(op[0], result[0], overflow[0]);
        mask = c1[5] || (op[1] == OP_ERET);
        en_exp = {regwrite[1] & !c1[5], regwrite[0] & !c0[5] & !mask};
        ms = (mem_load(op[1]) || mem_store(op[1])) ? 1 : 0;
        acc = ms ? !c1[5] : ((mem_load(op[0]) || mem_store(op[0])) && !mask && !c0[5]);
        exc_v = c1[5] || (c0[5] && !mask);
        cyc = 0;
        while (!finish) begin
            @(negedge clk);
            first_cycle = 1'b0;
            cyc++;
            #1;
        end
        check("finish latency", cyc, acc ? READ_LATENCY + 1 : 0);
        check("wb_en", wb_en, en_exp);
        check("wb_reg", wb_reg, destreg);
        check("exception_valid", exception_valid, exc_v);
        if (exc_v) begin
            check("exception_code", exception_code, c1[5] ? c1[4:0] : c0[4:0]);
            check("exception_pc", exception_pc, c1[5] ? pc[1] : pc[0]);
        end
        idx = int'((result[ms] >> 2) % MEM_WORDS);
        w = shadow[idx];
        for (int s = 0; s < 2; s++) begin
            if (!mem_load(op[s]) && en_exp[s]) begin
                check($sformatf("wb_data[%0d]", s), wb_data[s], result[s]);
            end else if (acc && ms == s && mem_load(op[s]) && en_exp[s]) begin
                check($sformatf("wb_data[%0d]", s), wb_data[s],
                      extract(op[s], w, result[s][1:0]));
            end
        end
        // store lands only through the served slot
        if (acc && mem_store(op[ms])) begin
            for (int i = 0; i < 4; i++) begin
                if (op[ms] == OP_SW || (op[ms] == OP_SH && i / 2 == result[ms][1]) ||
                    (op[ms] == OP_SB && i == result[ms][1:0])) begin
                    w[8*i +: 8] = (op[ms] == OP_SB) ? store_data[ms][7:0] :
                                  (op[ms] == OP_SH) ? store_data[ms][8*(i%2) +: 8] :
                                  store_data[ms][8*i +: 8];
                end
            end
            shadow[idx] = w;
        end
        rv = 1'b1;
        rpc = EXC_VECTOR;
        if (exc_v) rpc = EXC_VECTOR;
        else if (op[1] == OP_ERET) rpc = epc[1];
        else if (op[0] == OP_ERET) rpc = epc[0];
        else if (op[1] == OP_JR) rpc = srca[1];
        else if (op[1] == OP_BRANCH && taken[1] != pred_taken[1])
            rpc = taken[1] ? pcbranch[1] : pc[0];
        else if (op[1] == OP_JUMP && !pred_taken[1]) rpc = pcjump[1];
        else rv = 1'b0;
        check("redirect_valid", redirect_valid, rv);
        if (rv) check("redirect_pc", redirect_pc, rpc);
    endtask

    // biased toward loads and stores inside a 16-word window
    task automatic rand_slot(input int s);
        logic [31:0] r;
        r = $random(seed);
        op[s] = (r[4:0] < 5'd20) ? op_t'(1 + r[8:5] % 8) : op_t'(r[12:9]);
        result[s] = BASE | (r[15:14] == 2'b00 ? r[21:16] & 6'h3f : r[21:16] & 6'h3c);
        if (!(mem_load(op[s]) || mem_store(op[s]))) result[s] = $random(seed);
        store_data[s] = $random(seed);
        srca[s] = $random(seed);
        regwrite[s] = r[22];
        overflow[s] = r[23] & r[24];
        taken[s] = r[25];
        pred_taken[s] = r[26];
        destreg[s] = r[31:27];
    endtask

    task automatic mem_pair(input op_t o, input word_t a, input word_t d);
        begin_pair();
        op[1] = o;
        result[1] = a;
        store_data[1] = d;
        regwrite[1] = 1'b1;
        run_pair();
    endtask

    initial begin
        rst_n = 1'b0;
        first_cycle = 1'b1;
        set_defaults();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < 16; i++) mem_pair(OP_SW, BASE + 4 * i, $random(seed));
        for (int n = 0; n < 300; n++) begin
            begin_pair();
            rand_slot(1);
            rand_slot(0);
            if (($random(seed) & 31) == 0) ext_int = 6'h4;
            if (($random(seed) & 31) == 1) timer_interrupt = 1'b1;
            run_pair();
        end
        // every size at every aligned offset, negative and positive values
        for (int a = 0; a < 4; a++) begin
            mem_pair(OP_SB, BASE + 32'h20 + a, 32'h9a - 8'(a * 64));
            mem_pair(OP_LB, BASE + 32'h20 + a, 0);
            mem_pair(OP_LBU, BASE + 32'h20 + a, 0);
        end
        for (int a = 0; a < 4; a += 2) begin
            mem_pair(OP_SH, BASE + 32'h24 + a, a ? 32'h7123 : 32'h8c3e);
            mem_pair(OP_LH, BASE + 32'h24 + a, 0);
            mem_pair(OP_LHU, BASE + 32'h24 + a, 0);
        end
        mem_pair(OP_SW, BASE + 32'h28, 32'hdead_beef);
        mem_pair(OP_SW, BASE + 32'h29, 32'h1111_1111);
        mem_pair(OP_LH, BASE + 32'h2b, 0);
        mem_pair(OP_LW, BASE + 32'h28, 0);
        // older syscall kills the younger store
        begin_pair();
        op[1] = OP_SYSCALL;
        op[0] = OP_SW;
        result[0] = BASE + 32'h28;
        store_data[0] = 32'h5555_5555;
        regwrite = 2'b11;
        run_pair();
        mem_pair(OP_LW, BASE + 32'h28, 0);
        begin_pair();
        op[0] = OP_BREAK;
        regwrite = 2'b11;
        run_pair();
        for (int k = 0; k < 5; k++) begin
            begin_pair();
            op[1] = op_t'(k == 0 ? OP_ERET : k == 1 ? OP_JR : k == 4 ? OP_JUMP : OP_BRANCH);
            op[0] = OP_SW;
            result[0] = BASE + 32'h2c;
            srca[1] = 32'h0040_0a00;
            regwrite = 2'b11;
            taken[1] = (k == 2);
            pred_taken[1] = (k == 3);
            run_pair();
        end
        // both stores, only the older one lands
        begin_pair();
        op[1] = OP_SW;
        op[0] = OP_SW;
        result = {BASE + 32'h30, BASE + 32'h30};
        store_data = {32'ha5a5_0001, 32'h0000_0bad};
        run_pair();
        mem_pair(OP_LW, BASE + 32'h30, 0);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/commit_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module commit_top import commit_pkg::*; #(
    parameter int MEM_WORDS    = 256,
    parameter int READ_LATENCY = 2
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  op_t   [1:0]          op,
    input  word_t [1:0]          result,
    input  word_t [1:0]          store_data,
    input  word_t [1:0]          srca,
    input  word_t [1:0]          pc,
    input  word_t [1:0]          pcbranch,
    input  word_t [1:0]          pcjump,
    input  logic  [1:0][4:0]     destreg,
    input  logic  [1:0]          regwrite,
    input  logic  [1:0]          overflow,
    input  logic  [1:0]          taken,
    input  logic  [1:0]          pred_taken,
    input  word_t [1:0]          epc,
    input  logic                 first_cycle,
    input  logic  [5:0]          ext_int,
    input  logic                 timer_interrupt,
    output logic                 finish,
    output logic  [1:0]          wb_en,
    output logic  [1:0][4:0]     wb_reg,
    output word_t [1:0]          wb_data,
    output logic                 exception_valid,
    output exc_code_t            exception_code,
    output word_t                exception_pc,
    output logic                 redirect_valid,
    output word_t                redirect_pc
);

    logic       dmem_en;
    logic       dmem_wt;
    word_t      dmem_addr;
    word_t      dmem_wd;
    logic [3:0] dmem_be;
    word_t      dmem_rd;
    logic       dmem_data_ok;

    commit_stage commit_stage_i (
        .clk, .rst_n,
        .op, .result, .store_data, .srca, .pc, .pcbranch, .pcjump,
        .destreg, .regwrite, .overflow, .taken, .pred_taken, .epc,
        .first_cycle, .ext_int, .timer_interrupt,
        .dmem_en, .dmem_wt, .dmem_addr, .dmem_wd, .dmem_be,
        .dmem_rd, .dmem_data_ok,
        .finish, .wb_en, .wb_reg, .wb_data,
        .exception_valid, .exception_code, .exception_pc,
        .redirect_valid, .redirect_pc
    );

    data_ram #(
        .MEM_WORDS(MEM_WORDS),
        .READ_LATENCY(READ_LATENCY)
    ) data_ram_i (
        .clk, .rst_n,
        .en(dmem_en), .wt(dmem_wt), .addr(dmem_addr), .wd(dmem_wd), .be(dmem_be),
        .rd(dmem_rd), .data_ok(dmem_data_ok)
    );

endmodule

`default_nettype wire

// ==== hdl/data_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module data_ram import commit_pkg::*; #(
    parameter int MEM_WORDS    = 256,
    parameter int READ_LATENCY = 2
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       en,
    input  logic       wt,
    input  word_t      addr,
    input  word_t      wd,
    input  logic [3:0] be,
    output word_t      rd,
    output logic       data_ok
);

    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam int CNT_W = $clog2(READ_LATENCY + 1);

    logic [3:0][7:0]  mem [MEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic [CNT_W-1:0] pending;
    logic             accept;

    assign idx = IDX_W'((addr >> 2) % MEM_WORDS);

    // the data_ok cycle is not idle, the old request is still on the bus
    assign accept = en && (pending == '0) && !data_ok;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= '0;
            data_ok <= 1'b0;
        end else begin
            data_ok <= 1'b0;
            if (accept) begin
                pending <= CNT_W'(READ_LATENCY);
            end else if (pending != '0) begin
                pending <= pending - 1'b1;
                data_ok <= pending == CNT_W'(1);
            end
        end
    end

    // array access lands on the edge that raises data_ok
    always_ff @(posedge clk) begin
        if (pending == CNT_W'(1)) begin
            if (wt) begin
                for (int i = 0; i < 4; i++) begin
                    if (be[i]) begin
                        mem[idx][i] <= wd[8*i +: 8];
                    end
                end
            end else begin
                rd <= mem[idx];
            end
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the commit stage regression with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sim.f --top-module commit_tb -o commit_sim \
    && ./obj_dir/commit_sim > sim.log 2>&1 \
    || { echo "build or run error"; exit 1; }

cat sim.log
grep -q "Regression failed" sim.log \
    && { echo "simulation reported failure"; exit 1; } \
    || { echo "no failure found in sim.log"; exit 0; }

// ==== sim.f ====
common/commit_pkg.sv
commit/exception_checker.sv
commit/writedata_format.sv
commit/readdata_format.sv
commit/commit_stage.sv
hdl/data_ram.sv
hdl/commit_top.sv
dv/commit_tb.sv
